// File: ctrl_gen.sv
// Control generator
// Unit enables, operand-use flags and per-unit operation codes
// for ALU, branch unit, LSU, multiplier and divider
`timescale 1ns/1ps
`default_nettype none

module ctrl_gen (
    input  wire decode_pkg::instr_fields_t i_fields,
    output decode_pkg::ctrl_t              o_ctrl
);

    logic alu_r;        // OP without muldiv
    logic alu_any;      // Register or immediate ALU form
    logic ls_byte;      // LB, LBU, SB
    logic ls_half;      // LH, LHU, SH

    always_comb begin : class_terms
        alu_r   = i_fields.r & ~i_fields.muldiv;
        alu_any = alu_r | i_fields.i;
        ls_byte = (i_fields.l & (i_fields.funct3[0] | i_fields.funct3[4]))
                | (i_fields.s & i_fields.funct3[0]);
        ls_half = (i_fields.l & (i_fields.funct3[1] | i_fields.funct3[5]))
                | (i_fields.s & i_fields.funct3[1]);
    end

    always_comb begin : ctrl_decode
        // ============================
        // Unit enables
        // ============================
        o_ctrl.alu_en    = alu_r | i_fields.i | i_fields.lui | i_fields.auipc;
        o_ctrl.branch_en = i_fields.b | i_fields.jal | i_fields.jalr;
        o_ctrl.load_en   = i_fields.l;
        o_ctrl.store_en  = i_fields.s;
        o_ctrl.mul_en    = i_fields.r & i_fields.muldiv & (|i_fields.funct3[3:0]);
        o_ctrl.div_en    = i_fields.r & i_fields.muldiv & (|i_fields.funct3[7:4]);

        // Operand usage, all low when unsupported
        o_ctrl.use_rs1 = i_fields.r | i_fields.i | i_fields.l | i_fields.s
                       | i_fields.b | i_fields.jalr;
        o_ctrl.use_rs2 = i_fields.r | i_fields.s | i_fields.b;
        o_ctrl.use_pc  = i_fields.b | i_fields.auipc | i_fields.jal;
        o_ctrl.use_imm = i_fields.i | i_fields.l | i_fields.s | i_fields.b
                       | i_fields.lui | i_fields.auipc | i_fields.jal | i_fields.jalr;
        o_ctrl.wren    = i_fields.r | i_fields.i | i_fields.l | i_fields.lui
                       | i_fields.auipc | i_fields.jal | i_fields.jalr;  // No rd for S/B

        // ============================
        // ALU
        // ============================
        o_ctrl.alu_op = decode_pkg::ALU_ADD;           // Also LUI/AUIPC
        if (alu_any) begin
            if (i_fields.funct3[2] | i_fields.funct3[3])      o_ctrl.alu_op = decode_pkg::ALU_CMP;
            else if (i_fields.funct3[1] | i_fields.funct3[5]) o_ctrl.alu_op = decode_pkg::ALU_SHIFT;
            else if (i_fields.funct3[4])                      o_ctrl.alu_op = decode_pkg::ALU_XOR;
            else if (i_fields.funct3[6])                      o_ctrl.alu_op = decode_pkg::ALU_OR;
            else if (i_fields.funct3[7])                      o_ctrl.alu_op = decode_pkg::ALU_AND;
        end else if (i_fields.jal | i_fields.jalr) begin
            o_ctrl.alu_op = decode_pkg::ALU_LINK;      // rd = pc + 4
        end

        o_ctrl.alu_sub_en     = alu_r & i_fields.funct3[0] & i_fields.alt;  // SUB only
        o_ctrl.alu_signed_cmp = alu_any & i_fields.funct3[2];               // SLT, SLTI

        o_ctrl.alu_shift_ctrl = decode_pkg::SHIFT_SRL;
        if (alu_any & i_fields.funct3[1])
            o_ctrl.alu_shift_ctrl = decode_pkg::SHIFT_SLL;
        else if (alu_any & i_fields.funct3[5] & i_fields.alt)
            o_ctrl.alu_shift_ctrl = decode_pkg::SHIFT_SRA;

        // ============================
        // Branch, LSU, mul/div
        // ============================
        o_ctrl.branch_op = {i_fields.jalr, i_fields.jal,
                            {6{i_fields.b}} & {i_fields.funct3[7:4], i_fields.funct3[1:0]}};

        // Word unless byte or half, also for non-memory ops
        o_ctrl.lsu_bytemask = {~(ls_byte | ls_half), ~(ls_byte | ls_half), ~ls_byte, 1'b1};
        o_ctrl.lsu_signed   = i_fields.l & (i_fields.funct3[0] | i_fields.funct3[1]); // LB, LH

        // funct3[1:0] back out of the one-hot
        o_ctrl.mul_op = {2{o_ctrl.mul_en}}
                      & {i_fields.funct3[2] | i_fields.funct3[3],
                         i_fields.funct3[1] | i_fields.funct3[3]};
        o_ctrl.div_op = {2{o_ctrl.div_en}}
                      & {i_fields.funct3[6] | i_fields.funct3[7],
                         i_fields.funct3[5] | i_fields.funct3[7]};
    end

endmodule

`default_nettype wire

// File: decode_pkg.sv
// RV32IM decode stage shared definitions
// ISA opcodes, control encodings and the packets between the stages
`default_nettype none

package decode_pkg;

    // ============================
    // Widths
    // ============================
    localparam int XLEN       = 32;    // Data and address width
    localparam int REG_ADDR_W = 5;     // x0..x31

    // ============================
    // Opcodes (RV32IM subset)
    // ============================
    localparam logic [6:0] OPC_OP     = 7'b011_0011; // Register-register, incl. muldiv
    localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
    localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
    localparam logic [6:0] OPC_STORE  = 7'b010_0011;
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
    localparam logic [6:0] OPC_LUI    = 7'b011_0111;
    localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;

    // funct7 values of interest
    localparam logic [6:0] F7_BASE   = 7'h00;
    localparam logic [6:0] F7_ALT    = 7'h20;  // SUB, SRA, SRAI
    localparam logic [6:0] F7_MULDIV = 7'h01;  // M extension

    // ALU operation select
    localparam logic [2:0] ALU_ADD   = 3'd0;   // ADD/SUB, also LUI/AUIPC
    localparam logic [2:0] ALU_CMP   = 3'd1;   // SLT family
    localparam logic [2:0] ALU_SHIFT = 3'd2;
    localparam logic [2:0] ALU_XOR   = 3'd3;
    localparam logic [2:0] ALU_AND   = 3'd4;
    localparam logic [2:0] ALU_OR    = 3'd5;
    localparam logic [2:0] ALU_LINK  = 3'd6;   // pc + 4 for JAL/JALR

    // Immediate format select
    localparam logic [2:0] IMM_NONE  = 3'd0;
    localparam logic [2:0] IMM_I     = 3'd1;
    localparam logic [2:0] IMM_S     = 3'd2;
    localparam logic [2:0] IMM_B     = 3'd3;
    localparam logic [2:0] IMM_SHAMT = 3'd4;
    localparam logic [2:0] IMM_J     = 3'd5;
    localparam logic [2:0] IMM_U     = 3'd6;

    // Shifter control
    localparam logic [1:0] SHIFT_SRL = 2'd0;   // Default
    localparam logic [1:0] SHIFT_SLL = 2'd1;
    localparam logic [1:0] SHIFT_SRA = 2'd2;

    // ============================
    // Packets
    // ============================
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic            valid;
        logic            is_predicted;
        logic [XLEN-1:0] predicted_target;
    } fetch_t;

    // Raw fields plus one-hot and class flags
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [7:0]            funct3;  // One-hot of instr[14:12]
        logic r, i, l, s, b;            // OP, OP-IMM, LOAD, STORE, BRANCH
        logic lui, auipc, jal, jalr;
        logic base, alt, muldiv;        // funct7 flags
    } instr_fields_t;

    typedef struct packed {
        logic       alu_en;
        logic       branch_en;
        logic       load_en;
        logic       store_en;
        logic       mul_en;
        logic       div_en;
        logic       wren;
        logic       use_rs1;
        logic       use_rs2;
        logic       use_pc;
        logic       use_imm;
        logic [2:0] alu_op;
        logic       alu_sub_en;
        logic       alu_signed_cmp;
        logic [1:0] alu_shift_ctrl;
        logic [7:0] branch_op;          // BEQ..BGEU, JAL, JALR
        logic [3:0] lsu_bytemask;
        logic       lsu_signed;
        logic [1:0] mul_op;
        logic [1:0] div_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic                  is_predicted;
        logic [XLEN-1:0]       predicted_target;
    } decode_t;

    // Subset for the hazard unit
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  use_rs1;
        logic                  use_rs2;
        logic                  load_en;
        logic                  store_en;
        logic                  mul_en;
        logic                  div_en;
        logic                  wren;
    } hazard_t;

endpackage

`default_nettype wire

// File: field_decoder.sv
// Instruction field decoder
// Slices register indexes, one-hot decodes funct3 and flags funct7,
// classifies the opcode into one class flag, none when unsupported
`timescale 1ns/1ps
`default_nettype none

module field_decoder (
    input  wire logic [decode_pkg::XLEN-1:0] i_instr,   // Raw instruction word
    output decode_pkg::instr_fields_t        o_fields   // Decoded fields and flags
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // ============================
    // Field extraction
    // ============================
    always_comb begin : field_extract
        opcode = i_instr[6:0];
        funct3 = i_instr[14:12];
        funct7 = i_instr[31:25];
    end

    // ============================
    // Decode
    // ============================
    always_comb begin : field_decode
        // Register indexes pass straight through
        o_fields.rs1    = i_instr[19:15];
        o_fields.rs2    = i_instr[24:20];
        o_fields.rd     = i_instr[11:7];

        o_fields.funct3 = 8'b0000_0001 << funct3;       // Binary to one-hot

        // Opcode classes, at most one high
        o_fields.r      = (opcode == decode_pkg::OPC_OP);
        o_fields.i      = (opcode == decode_pkg::OPC_OP_IMM);
        o_fields.l      = (opcode == decode_pkg::OPC_LOAD);
        o_fields.s      = (opcode == decode_pkg::OPC_STORE);
        o_fields.b      = (opcode == decode_pkg::OPC_BRANCH);
        o_fields.lui    = (opcode == decode_pkg::OPC_LUI);
        o_fields.auipc  = (opcode == decode_pkg::OPC_AUIPC);
        o_fields.jal    = (opcode == decode_pkg::OPC_JAL);
        o_fields.jalr   = (opcode == decode_pkg::OPC_JALR);

        // funct7 flags, meaningful for OP and shift immediates only
        o_fields.base   = (funct7 == decode_pkg::F7_BASE);
        o_fields.alt    = (funct7 == decode_pkg::F7_ALT);    // SUB / SRA
        o_fields.muldiv = (funct7 == decode_pkg::F7_MULDIV); // M extension
    end

endmodule

`default_nettype wire

// File: imm_gen.sv
// Immediate generator
// Builds all six RISC-V immediate formats, then selects one by class
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire logic [decode_pkg::XLEN-1:0] i_instr,
    input  wire decode_pkg::instr_fields_t   i_fields,
    output logic [decode_pkg::XLEN-1:0]      o_imm
);

    logic [decode_pkg::XLEN-1:0] imm_i;     // OP-IMM, LOAD, JALR
    logic [decode_pkg::XLEN-1:0] imm_s;     // STORE
    logic [decode_pkg::XLEN-1:0] imm_b;     // BRANCH
    logic [decode_pkg::XLEN-1:0] imm_sh;    // SLLI/SRLI/SRAI
    logic [decode_pkg::XLEN-1:0] imm_j;     // JAL
    logic [decode_pkg::XLEN-1:0] imm_u;     // LUI, AUIPC
    logic [2:0]                  imm_sel;
    logic                        shamt_form;

    // ============================
    // Formats
    // ============================
    always_comb begin : imm_formats
        imm_i  = {{20{i_instr[31]}}, i_instr[31:20]};
        imm_s  = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
        imm_b  = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
        imm_sh = {27'd0, i_instr[24:20]};                 // Zero-extended shamt
        imm_j  = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
        imm_u  = {i_instr[31:12], 12'h000};
    end

    // Shift immediates win over the plain I form
    always_comb begin : imm_select
        shamt_form = i_fields.i & (i_fields.funct3[1] | i_fields.funct3[5]);
        if (shamt_form)                                 imm_sel = decode_pkg::IMM_SHAMT;
        else if (i_fields.i | i_fields.l | i_fields.jalr) imm_sel = decode_pkg::IMM_I;
        else if (i_fields.s)                            imm_sel = decode_pkg::IMM_S;
        else if (i_fields.b)                            imm_sel = decode_pkg::IMM_B;
        else if (i_fields.jal)                          imm_sel = decode_pkg::IMM_J;
        else if (i_fields.lui | i_fields.auipc)         imm_sel = decode_pkg::IMM_U;
        else                                            imm_sel = decode_pkg::IMM_NONE;
    end

    always_comb begin : imm_mux
        case (imm_sel)
            decode_pkg::IMM_I:     o_imm = imm_i;
            decode_pkg::IMM_S:     o_imm = imm_s;
            decode_pkg::IMM_B:     o_imm = imm_b;
            decode_pkg::IMM_SHAMT: o_imm = imm_sh;
            decode_pkg::IMM_J:     o_imm = imm_j;
            decode_pkg::IMM_U:     o_imm = imm_u;
            default:               o_imm = '0;        // OP and unsupported
        endcase
    end

endmodule

`default_nettype wire

// File: instr_decoder_props.sv
// Handshake properties of the decode stage
// Bound into the top level to watch the output register and ready
`timescale 1ns/1ps
`default_nettype none

module instr_decoder_props (
    input wire logic                i_clk,
    input wire logic                i_arst_n,
    input wire logic                i_ready,          // Downstream ready
    input wire logic                i_stage_ready,    // Stage ready toward fetch
    input wire decode_pkg::decode_t i_decode,
    input wire logic                i_decode_valid,
    input wire decode_pkg::hazard_t i_hazard,
    input wire logic                i_hazard_valid
);

    int assert_fail_count = 0;                        // Failed property checks

    // ==============================
    // Properties
    // ==============================
    assert property (@(posedge i_clk) !i_arst_n |-> (!i_decode_valid && !i_hazard_valid))
        else begin
            $error("Output valid high while reset is asserted");
            assert_fail_count++;
        end

    // Back-pressure holds the payload
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
                     (i_decode_valid && !i_ready) |=> ($stable(i_decode) && $stable(i_hazard)))
        else begin
            $error("Payload changed while stalled");
            assert_fail_count++;
        end

    assert property (@(posedge i_clk) disable iff (!i_arst_n) i_decode_valid == i_hazard_valid)
        else begin
            $error("Decode and hazard valid bits differ");
            assert_fail_count++;
        end

    assert property (@(posedge i_clk) disable iff (!i_arst_n)
                     !i_stage_ready |-> (i_decode_valid && !i_ready))
        else begin
            $error("Ready low without a stalled packet");
            assert_fail_count++;
        end

endmodule

bind instr_decoder_top instr_decoder_props u_props (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_ready        (i_ready),
    .i_stage_ready  (o_ready),
    .i_decode       (o_decode),
    .i_decode_valid (o_decode_valid),
    .i_hazard       (o_hazard),
    .i_hazard_valid (o_hazard_valid)
);

`default_nettype wire

// File: instr_decoder_top.sv
// RV32IM instruction decode stage
// Field decode feeds immediate and control generation in parallel,
// results are registered as a decode packet and a hazard packet
`timescale 1ns/1ps
`default_nettype none

module instr_decoder_top (
    input  wire logic                i_clk,
    input  wire logic                i_arst_n,
    input  wire logic                i_flush,
    input  wire decode_pkg::fetch_t  i_fetch,          // From fetch, valid inside
    input  wire logic                i_ready,          // Downstream ready
    output logic                     o_ready,
    output decode_pkg::decode_t      o_decode,
    output logic                     o_decode_valid,
    output decode_pkg::hazard_t      o_hazard,
    output logic                     o_hazard_valid
);

    decode_pkg::instr_fields_t   fields;
    decode_pkg::ctrl_t           ctrl;
    logic [decode_pkg::XLEN-1:0] imm;
    decode_pkg::decode_t         decode_next;
    decode_pkg::hazard_t         hazard_next;

    // ============================
    // Combinational decode
    // ============================
    field_decoder u_field_decoder (
        .i_instr  (i_fetch.instr),
        .o_fields (fields)
    );

    imm_gen u_imm_gen (
        .i_instr  (i_fetch.instr),
        .i_fields (fields),
        .o_imm    (imm)
    );

    ctrl_gen u_ctrl_gen (
        .i_fields (fields),
        .o_ctrl   (ctrl)
    );

    // Packet assembly
    always_comb begin : packet_pack
        decode_next.ctrl             = ctrl;
        decode_next.rs1              = fields.rs1;
        decode_next.rs2              = fields.rs2;
        decode_next.rd               = fields.rd;
        decode_next.imm              = imm;
        decode_next.pc               = i_fetch.pc;
        decode_next.is_predicted     = i_fetch.is_predicted;
        decode_next.predicted_target = i_fetch.predicted_target;

        hazard_next.rs1      = fields.rs1;      // Same source as the decode packet
        hazard_next.rs2      = fields.rs2;
        hazard_next.rd       = fields.rd;
        hazard_next.use_rs1  = ctrl.use_rs1;
        hazard_next.use_rs2  = ctrl.use_rs2;
        hazard_next.load_en  = ctrl.load_en;
        hazard_next.store_en = ctrl.store_en;
        hazard_next.mul_en   = ctrl.mul_en;
        hazard_next.div_en   = ctrl.div_en;
        hazard_next.wren     = ctrl.wren;
    end

    // ============================
    // Output registers
    // ============================
    stage_reg #(.payload_t(decode_pkg::decode_t)) u_decode_reg (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_flush  (i_flush),
        .i_valid  (i_fetch.valid),
        .i_ready  (i_ready),
        .i_data   (decode_next),
        .o_ready  (o_ready),
        .o_valid  (o_decode_valid),
        .o_data   (o_decode)
    );

    // Same handshake, so its ready matches the one above
    stage_reg #(.payload_t(decode_pkg::hazard_t)) u_hazard_reg (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_flush  (i_flush),
        .i_valid  (i_fetch.valid),
        .i_ready  (i_ready),
        .i_data   (hazard_next),
        .o_ready  (),
        .o_valid  (o_hazard_valid),
        .o_data   (o_hazard)
    );

endmodule

`default_nettype wire

// File: project.f
decode_pkg.sv
field_decoder.sv
imm_gen.sv
ctrl_gen.sv
stage_reg.sv
instr_decoder_top.sv
instr_decoder_props.sv
tb_instr_decoder.sv

// File: stage_reg.sv
// Pipeline stage register with valid/ready handshake and flush
// Holds one item, accepts a new one on the edge the old one leaves
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     i_clk,
    input  wire logic     i_arst_n,
    input  wire logic     i_flush,     // Drops the held item and the input
    input  wire logic     i_valid,
    input  wire logic     i_ready,     // Downstream can take the item
    input  wire payload_t i_data,
    output logic          o_ready,
    output logic          o_valid,
    output payload_t      o_data
);

    logic     valid_q;
    payload_t data_q;
    logic     accept;

    assign o_ready = i_ready | ~valid_q;        // Empty or draining this edge
    assign accept  = i_valid & o_ready & ~i_flush;

    always_ff @(posedge i_clk or negedge i_arst_n) begin : stage_seq
        if (!i_arst_n) begin
            valid_q <= 1'b0;
            data_q  <= '0;
        end else begin
            if (i_flush)
                valid_q <= 1'b0;
            else if (o_ready)
                valid_q <= i_valid;             // Refill or go empty
            if (accept)
                data_q <= i_data;               // Hold otherwise
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule

`default_nettype wire

// File: tb_instr_decoder.sv
// Testbench for the RV32IM decode stage
// Random fetch packets and back-pressure, checked against a reference decode
// model and a one-entry queue that models the output register
`timescale 1ns/1ps
`default_nettype none

module tb_instr_decoder;

    logic                i_clk;
    logic                i_arst_n;
    logic                i_flush;
    logic                i_ready;
    decode_pkg::fetch_t  i_fetch;
    logic                o_ready;
    decode_pkg::decode_t o_decode;
    logic                o_decode_valid;
    decode_pkg::hazard_t o_hazard;
    logic                o_hazard_valid;

    decode_pkg::decode_t exp_q[$];              // Packets inside the stage
    int                  error_count = 0;
    int                  check_count = 0;
    int                  accept_count = 0;
    int                  wait_cycles;

    instr_decoder_top instr_decoder_top_inst (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_flush        (i_flush),
        .i_fetch        (i_fetch),
        .i_ready        (i_ready),
        .o_ready        (o_ready),
        .o_decode       (o_decode),
        .o_decode_valid (o_decode_valid),
        .o_hazard       (o_hazard),
        .o_hazard_valid (o_hazard_valid)
    );

    always #20 i_clk = ~i_clk;                  // 40 ns period

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        check_count++;
        if (exp !== got) begin
            error_count++;
            $display("Mismatch %s exp=%0h got=%0h", name, exp, got);
        end
    endtask

    // ==============================
    // Reference decode model
    // ==============================
    function automatic decode_pkg::ctrl_t alu_ctrl(input decode_pkg::ctrl_t c,
                                                   input logic [2:0] f3,
                                                   input logic [6:0] f7,
                                                   input logic reg_form);
        decode_pkg::ctrl_t r;
        r        = c;
        r.alu_en = 1'b1;
        case (f3)
            3'd0:       r.alu_op = decode_pkg::ALU_ADD;
            3'd1, 3'd5: r.alu_op = decode_pkg::ALU_SHIFT;
            3'd2, 3'd3: r.alu_op = decode_pkg::ALU_CMP;     // SLT / SLTU
            3'd4:       r.alu_op = decode_pkg::ALU_XOR;
            3'd6:       r.alu_op = decode_pkg::ALU_OR;
            default:    r.alu_op = decode_pkg::ALU_AND;
        endcase
        r.alu_sub_en     = reg_form && (f3 == 3'd0) && (f7 == decode_pkg::F7_ALT);
        r.alu_signed_cmp = (f3 == 3'd2);
        if (f3 == 3'd1)
            r.alu_shift_ctrl = decode_pkg::SHIFT_SLL;
        else if (f3 == 3'd5 && f7 == decode_pkg::F7_ALT)
            r.alu_shift_ctrl = decode_pkg::SHIFT_SRA;
        return r;
    endfunction

    function automatic decode_pkg::decode_t ref_decode(input decode_pkg::fetch_t f);
        decode_pkg::decode_t d;
        logic [31:0]         w;
        logic [2:0]          f3;
        logic [6:0]          f7;
        w  = f.instr;
        f3 = w[14:12];
        f7 = w[31:25];
        d  = '0;
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.rd  = w[11:7];
        d.pc               = f.pc;
        d.is_predicted     = f.is_predicted;
        d.predicted_target = f.predicted_target;
        d.ctrl.lsu_bytemask = 4'hf;                         // Word unless a narrow access
        case (w[6:0])
            decode_pkg::OPC_OP: begin
                d.ctrl.use_rs1 = 1'b1;
                d.ctrl.use_rs2 = 1'b1;
                d.ctrl.wren    = 1'b1;
                if (f7 == decode_pkg::F7_MULDIV) begin
                    d.ctrl.mul_en = (f3 < 3'd4);
                    d.ctrl.div_en = (f3 >= 3'd4);
                    if (f3 < 3'd4) d.ctrl.mul_op = f3[1:0];
                    else           d.ctrl.div_op = f3[1:0];
                end else begin
                    d.ctrl = alu_ctrl(d.ctrl, f3, f7, 1'b1);
                end
            end
            decode_pkg::OPC_OP_IMM: begin
                d.ctrl = alu_ctrl(d.ctrl, f3, f7, 1'b0);
                d.ctrl.use_rs1 = 1'b1;
                d.ctrl.use_imm = 1'b1;
                d.ctrl.wren    = 1'b1;
                if (f3 == 3'd1 || f3 == 3'd5) d.imm = {27'b0, w[24:20]};  // Shift amount
                else                          d.imm = {{20{w[31]}}, w[31:20]};
            end
            decode_pkg::OPC_LOAD: begin
                d.ctrl.load_en = 1'b1;
                d.ctrl.use_rs1 = 1'b1;
                d.ctrl.use_imm = 1'b1;
                d.ctrl.wren    = 1'b1;
                d.imm          = {{20{w[31]}}, w[31:20]};
                if (f3[1:0] == 2'd0)      d.ctrl.lsu_bytemask = 4'h1;     // LB, LBU
                else if (f3[1:0] == 2'd1) d.ctrl.lsu_bytemask = 4'h3;     // LH, LHU
                d.ctrl.lsu_signed = (f3 == 3'd0) || (f3 == 3'd1);
            end
            decode_pkg::OPC_STORE: begin
                d.ctrl.store_en = 1'b1;
                d.ctrl.use_rs1  = 1'b1;
                d.ctrl.use_rs2  = 1'b1;
                d.ctrl.use_imm  = 1'b1;
                d.imm           = {{20{w[31]}}, w[31:25], w[11:7]};
                if (f3 == 3'd0)      d.ctrl.lsu_bytemask = 4'h1;
                else if (f3 == 3'd1) d.ctrl.lsu_bytemask = 4'h3;
            end
            decode_pkg::OPC_BRANCH: begin
                d.ctrl.branch_en = 1'b1;
                d.ctrl.use_rs1   = 1'b1;
                d.ctrl.use_rs2   = 1'b1;
                d.ctrl.use_pc    = 1'b1;
                d.ctrl.use_imm   = 1'b1;
                d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                case (f3)                                   // BEQ BNE BLT BGE BLTU BGEU
                    3'd0:    d.ctrl.branch_op = 8'h01;
                    3'd1:    d.ctrl.branch_op = 8'h02;
                    3'd4:    d.ctrl.branch_op = 8'h04;
                    3'd5:    d.ctrl.branch_op = 8'h08;
                    3'd6:    d.ctrl.branch_op = 8'h10;
                    3'd7:    d.ctrl.branch_op = 8'h20;
                    default: d.ctrl.branch_op = 8'h00;
                endcase
            end
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
                d.ctrl.alu_en  = 1'b1;
                d.ctrl.use_pc  = (w[6:0] == decode_pkg::OPC_AUIPC);
                d.ctrl.use_imm = 1'b1;
                d.ctrl.wren    = 1'b1;
                d.imm          = {w[31:12], 12'b0};
            end
            decode_pkg::OPC_JAL, decode_pkg::OPC_JALR: begin
                d.ctrl.branch_en = 1'b1;
                d.ctrl.use_imm   = 1'b1;
                d.ctrl.wren      = 1'b1;
                d.ctrl.alu_op    = decode_pkg::ALU_LINK;
                if (w[6:0] == decode_pkg::OPC_JAL) begin
                    d.ctrl.use_pc    = 1'b1;
                    d.ctrl.branch_op = 8'h40;
                    d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end else begin
                    d.ctrl.use_rs1   = 1'b1;
                    d.ctrl.branch_op = 8'h80;
                    d.imm            = {{20{w[31]}}, w[31:20]};
                end
            end
            default: ;                                  // Unsupported opcode leaves all zero
        endcase
        return d;
    endfunction

    function automatic decode_pkg::hazard_t hazard_of(input decode_pkg::decode_t d);
        decode_pkg::hazard_t h;
        h = '{rs1: d.rs1, rs2: d.rs2, rd: d.rd, use_rs1: d.ctrl.use_rs1,
              use_rs2: d.ctrl.use_rs2, load_en: d.ctrl.load_en, store_en: d.ctrl.store_en,
              mul_en: d.ctrl.mul_en, div_en: d.ctrl.div_en, wren: d.ctrl.wren};
        return h;
    endfunction

    // Random fetch packet weighted toward the supported classes
    function automatic decode_pkg::fetch_t random_fetch();
        decode_pkg::fetch_t f;
        logic [31:0]        w;
        w = $urandom();
        case ($urandom_range(0, 11))
            0:  begin
                w[6:0] = decode_pkg::OPC_OP;
                if ($urandom_range(0, 1))               // Base funct7 half the time
                    w[31:25] = 7'h00;
            end
            1:  begin
                w[6:0]   = decode_pkg::OPC_OP;
                w[31:25] = decode_pkg::F7_ALT;
            end
            2:  begin
                w[6:0]   = decode_pkg::OPC_OP;
                w[31:25] = decode_pkg::F7_MULDIV;
            end
            3:  begin
                w[6:0] = decode_pkg::OPC_OP_IMM;
                if ($urandom_range(0, 1))               // Legal SRLI/SRAI funct7
                    w[31:25] = $urandom_range(0, 1) ? decode_pkg::F7_ALT : decode_pkg::F7_BASE;
            end
            4:  w[6:0] = decode_pkg::OPC_LOAD;
            5:  w[6:0] = decode_pkg::OPC_STORE;
            6:  w[6:0] = decode_pkg::OPC_BRANCH;
            7:  w[6:0] = decode_pkg::OPC_LUI;
            8:  w[6:0] = decode_pkg::OPC_AUIPC;
            9:  w[6:0] = decode_pkg::OPC_JAL;
            10: w[6:0] = decode_pkg::OPC_JALR;
            default: begin
                case ($urandom_range(0, 3))             // FENCE, SYSTEM, OP-FP, reserved
                    0:       w[6:0] = 7'h0f;
                    1:       w[6:0] = 7'h73;
                    2:       w[6:0] = 7'h53;
                    default: w[6:0] = 7'h7f;
                endcase
            end
        endcase
        f.pc               = $urandom();
        f.pc[1:0]          = 2'b00;
        f.instr            = w;
        f.valid            = ($urandom_range(0, 3) != 0);
        f.is_predicted     = $urandom_range(0, 1);
        f.predicted_target = $urandom();
        return f;
    endfunction

    // ==============================
    // Output check and stage model
    // ==============================
    always @(negedge i_clk) begin : output_check
        decode_pkg::decode_t exp_pkt;
        logic                model_valid;
        logic                model_ready;
        model_valid = (exp_q.size() != 0);
        model_ready = i_ready | ~model_valid;           // Empty or draining
        if (!i_arst_n) begin
            check_value("o_decode_valid", 64'd0, o_decode_valid);
            check_value("o_hazard_valid", 64'd0, o_hazard_valid);
            check_value("o_ready", 64'd1, o_ready);     // Empty stage takes input
        end else begin
            check_value("o_decode_valid", model_valid, o_decode_valid);
            check_value("o_hazard_valid", model_valid, o_hazard_valid);
            check_value("o_ready", model_ready, o_ready);
            if (model_valid) begin
                exp_pkt = exp_q[0];
                check_value("o_decode.ctrl", exp_pkt.ctrl, o_decode.ctrl);
                check_value("o_decode.rs1", exp_pkt.rs1, o_decode.rs1);
                check_value("o_decode.rs2", exp_pkt.rs2, o_decode.rs2);
                check_value("o_decode.rd", exp_pkt.rd, o_decode.rd);
                check_value("o_decode.imm", exp_pkt.imm, o_decode.imm);
                check_value("o_decode.pc", exp_pkt.pc, o_decode.pc);
                check_value("o_decode.is_predicted", exp_pkt.is_predicted,
                            o_decode.is_predicted);
                check_value("o_decode.predicted_target", exp_pkt.predicted_target,
                            o_decode.predicted_target);
                check_value("o_hazard", hazard_of(exp_pkt), o_hazard);
            end
            // Effect of the coming rising edge
            if (i_flush) begin
                exp_q.delete();
            end else begin
                if (model_valid && i_ready)
                    exp_q.delete(0);
                if (i_fetch.valid && model_ready) begin
                    exp_q.push_back(ref_decode(i_fetch));
                    accept_count++;
                end
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        i_clk    = 1'b0;
        i_arst_n = 1'b0;
        i_flush  = 1'b0;
        i_ready  = 1'b0;
        i_fetch  = '0;
        void'($urandom(33172));
        repeat (3) @(posedge i_clk);                    // Reset for 3 cycles
        i_arst_n <= 1'b1;
        repeat (2000) begin
            @(posedge i_clk);
            i_fetch <= random_fetch();
            i_ready <= ($urandom_range(0, 9) < 7);
            i_flush <= ($urandom_range(0, 24) == 0);    // Rare flush
        end
        @(posedge i_clk);
        i_fetch.valid <= 1'b0;
        i_ready       <= 1'b1;
        i_flush       <= 1'b0;
        wait_cycles = 0;
        while ((exp_q.size() != 0 || o_decode_valid) && wait_cycles < 20) begin
            @(posedge i_clk);
            wait_cycles++;
        end
        @(posedge i_clk);
        if (exp_q.size() != 0 || o_decode_valid) begin
            error_count++;
            $display("Timeout while waiting for the output stage to drain");
        end
        error_count += instr_decoder_top_inst.u_props.assert_fail_count;
        $display("Done: %0d packets accepted, %0d checks, %0d errors",
                 accept_count, check_count, error_count);
        if (error_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
